//--- rtl/lifo_stack_pkg.sv
// LIFO stack shared definitions
`default_nettype none

package lifo_stack_pkg;

  // Wishbone data word and register word index
  typedef logic [31:0] wb_data_t;
  typedef logic [1:0]  wb_addr_t;

  // Register map
  localparam wb_addr_t REG_DATA   = 2'd0;
  localparam wb_addr_t REG_TOP    = 2'd1;
  localparam wb_addr_t REG_STATUS = 2'd2;

  // Status word layout, count in bits 15 to 8
  localparam int STATUS_EMPTY     = 0;
  localparam int STATUS_FULL      = 1;
  localparam int STATUS_OVERFLOW  = 2;
  localparam int STATUS_UNDERFLOW = 3;
  localparam int STATUS_COUNT_LSB = 8;

  // Defaults, depth a power of two up to 128
  localparam int DEFAULT_WIDTH = 16;
  localparam int DEFAULT_DEPTH = 8;

  // Bus port states
  typedef enum logic {IDLE, ACK} port_state_e;

endpackage

`default_nettype wire

//--- rtl/stack_memory.sv
// Stack register-file storage
`timescale 1ns/1ps
`default_nettype none

module stack_memory
  import lifo_stack_pkg::*;
#(
  parameter int WIDTH = DEFAULT_WIDTH,
  parameter int DEPTH = DEFAULT_DEPTH
) (
  input  logic                     clock,
  input  logic                     memory_enable,
  input  logic                     memory_write_enable,
  input  logic [$clog2(DEPTH)-1:0] memory_address,
  input  logic [WIDTH-1:0]         memory_write_data,
  output logic [WIDTH-1:0]         memory_read_data
);

  localparam int ADDR_WIDTH = $clog2(DEPTH);

  // Word array, contents undefined until written
  logic [WIDTH-1:0] memory [DEPTH];

  // Write on the rising edge when selected
  always_ff @(posedge clock) begin
    if (memory_enable && memory_write_enable) begin
      memory[memory_address] <= memory_write_data;
    end
  end

  // Zero-latency read, shows the word before a same-cycle write
  assign memory_read_data = memory[memory_address[ADDR_WIDTH-1:0]];

endmodule

`default_nettype wire

//--- rtl/lifo_controller.sv
// LIFO stack pointer controller
`timescale 1ns/1ps
`default_nettype none

module lifo_controller
  import lifo_stack_pkg::*;
#(
  parameter int WIDTH = DEFAULT_WIDTH,
  parameter int DEPTH = DEFAULT_DEPTH
) (
  input  logic                         clock,
  input  logic                         resetn,
  // Operation strobes
  input  logic                         push,
  input  logic                         pop,
  input  logic                         peek,
  input  logic [WIDTH-1:0]             write_data,
  output logic [WIDTH-1:0]             read_data,
  // Status
  output logic                         full,
  output logic                         empty,
  output logic [7:0]                   count,
  output logic                         overflow,
  output logic                         underflow,
  // Memory side
  output logic                         memory_enable,
  output logic                         memory_write_enable,
  output logic [$clog2(DEPTH)-1:0]     memory_address,
  output logic [WIDTH-1:0]             memory_write_data,
  input  logic [WIDTH-1:0]             memory_read_data
);

  localparam int ADDR_WIDTH = $clog2(DEPTH);

  // One extra bit so a full stack is distinct from an empty one
  logic [ADDR_WIDTH:0] pointer;
  logic [ADDR_WIDTH:0] pointer_minus_one;
  logic                push_only;
  logic                pop_only;
  logic                replace;
  logic                push_ok;
  logic                pop_ok;
  logic                replace_ok;

  assign full  = (pointer == DEPTH[ADDR_WIDTH:0]);
  assign empty = (pointer == '0);
  // Occupancy zero-extended to the status field
  assign count = 8'(pointer);

  // Push and pop together replace the top word
  assign replace   = push && pop;
  assign push_only = push && !pop;
  assign pop_only  = pop && !push;

  // Guarding
  assign push_ok    = push_only && !full;
  assign pop_ok     = pop_only && !empty;
  assign replace_ok = replace && !empty;
  assign overflow   = push_only && full;
  // Covers both a plain pop and a replace
  assign underflow  = pop && empty;

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      pointer <= '0;
    end else if (push_ok) begin
      pointer <= pointer + 1'b1;
    end else if (pop_ok) begin
      pointer <= pointer - 1'b1;
    end
  end

  // Top word lives one below the pointer
  assign pointer_minus_one = pointer - 1'b1;

  assign memory_enable       = push || pop || peek;
  assign memory_write_enable = push_ok || replace_ok;
  // Push writes at the pointer, everything else hits the top word
  assign memory_address      = push_only ? pointer[ADDR_WIDTH-1:0]
                                         : pointer_minus_one[ADDR_WIDTH-1:0];
  assign memory_write_data   = write_data;

  // Pre-write value, zero when there is no top word
  assign read_data = empty ? '0 : memory_read_data;

  // Pointer stays within the array
  assert property (@(posedge clock) disable iff (!resetn)
    pointer <= DEPTH[ADDR_WIDTH:0]);

  // No write strobe without the memory being selected
  assert property (@(posedge clock) disable iff (!resetn)
    memory_write_enable |-> memory_enable);

endmodule

`default_nettype wire

//--- rtl/wb_stack_port.sv
// Wishbone slave port for the stack
`timescale 1ns/1ps
`default_nettype none

module wb_stack_port
  import lifo_stack_pkg::*;
#(
  parameter int WIDTH = DEFAULT_WIDTH
) (
  input  logic             clock,
  input  logic             resetn,
  // Wishbone classic slave
  input  logic             cyc,
  input  logic             stb,
  input  logic             we,
  input  wb_addr_t         adr,
  input  wb_data_t         dat_w,
  output wb_data_t         dat_r,
  output logic             ack,
  // Controller strobes
  output logic             push,
  output logic             pop,
  output logic             peek,
  output logic [WIDTH-1:0] write_data,
  input  logic [WIDTH-1:0] read_data,
  // Controller status
  input  logic             full,
  input  logic             empty,
  input  logic [7:0]       count,
  input  logic             overflow,
  input  logic             underflow
);

  port_state_e state;
  port_state_e state_next;
  logic        access;
  logic        status_write;
  logic        overflow_flag;
  logic        underflow_flag;
  wb_data_t    status_word;

  // Accept in IDLE, answer in the next cycle
  always_comb begin
    state_next = state;
    case (state)
      IDLE:    if (cyc && stb) state_next = ACK;
      ACK:     state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  assign ack = (state == ACK);

  // Operation decode, only in the ack cycle
  assign access       = ack && cyc && stb;
  assign push         = access && we && (adr == REG_DATA || adr == REG_TOP);
  assign pop          = access && (adr == REG_DATA ? !we : (adr == REG_TOP && we));
  assign peek         = access && !we && (adr == REG_TOP);
  assign status_write = access && we && (adr == REG_STATUS);

  // Upper bus bits dropped
  assign write_data = dat_w[WIDTH-1:0];

  // Sticky error flags
  always_ff @(posedge clock or negedge resetn) begin
    if (!resetn) begin
      overflow_flag  <= 1'b0;
      underflow_flag <= 1'b0;
    end else begin
      overflow_flag  <= (overflow_flag && !status_write) || overflow;
      underflow_flag <= (underflow_flag && !status_write) || underflow;
    end
  end

  // Status word from pre-operation state
  always_comb begin
    status_word                          = '0;
    status_word[STATUS_EMPTY]            = empty;
    status_word[STATUS_FULL]             = full;
    status_word[STATUS_OVERFLOW]         = overflow_flag;
    status_word[STATUS_UNDERFLOW]        = underflow_flag;
    status_word[STATUS_COUNT_LSB +: 8]   = count;
  end

  // Read mux, stack words zero-extended
  always_comb begin
    dat_r = '0;
    if (ack && !we) begin
      case (adr)
        REG_DATA, REG_TOP: dat_r = wb_data_t'(read_data);
        REG_STATUS:        dat_r = status_word;
        default:           dat_r = '0;
      endcase
    end
  end

  // Single-cycle ack
  assert property (@(posedge clock) disable iff (!resetn) ack |=> !ack);

  // Strobes only while acknowledging
  assert property (@(posedge clock) disable iff (!resetn)
    (state != ACK) |-> !(push || pop || peek));

endmodule

`default_nettype wire

//--- rtl/lifo_stack_top.sv
// LIFO stack top level
`timescale 1ns/1ps
`default_nettype none

module lifo_stack_top
  import lifo_stack_pkg::*;
#(
  parameter int WIDTH = DEFAULT_WIDTH,
  parameter int DEPTH = DEFAULT_DEPTH
) (
  input  logic     clock,
  input  logic     resetn,
  input  logic     cyc,
  input  logic     stb,
  input  logic     we,
  input  wb_addr_t adr,
  input  wb_data_t dat_w,
  output wb_data_t dat_r,
  output logic     ack
);

  localparam int ADDR_WIDTH = $clog2(DEPTH);

  // Port to controller
  logic             push;
  logic             pop;
  logic             peek;
  logic [WIDTH-1:0] write_data;
  logic [WIDTH-1:0] read_data;
  logic             full;
  logic             empty;
  logic [7:0]       count;
  logic             overflow;
  logic             underflow;

  // Controller to memory
  logic                  memory_enable;
  logic                  memory_write_enable;
  logic [ADDR_WIDTH-1:0] memory_address;
  logic [WIDTH-1:0]      memory_write_data;
  logic [WIDTH-1:0]      memory_read_data;

  wb_stack_port #(
    .WIDTH (WIDTH)
  ) wb_stack_port_inst (
    .clock      (clock),
    .resetn     (resetn),
    .cyc        (cyc),
    .stb        (stb),
    .we         (we),
    .adr        (adr),
    .dat_w      (dat_w),
    .dat_r      (dat_r),
    .ack        (ack),
    .push       (push),
    .pop        (pop),
    .peek       (peek),
    .write_data (write_data),
    .read_data  (read_data),
    .full       (full),
    .empty      (empty),
    .count      (count),
    .overflow   (overflow),
    .underflow  (underflow)
  );

  lifo_controller #(
    .WIDTH (WIDTH),
    .DEPTH (DEPTH)
  ) lifo_controller_inst (
    .clock               (clock),
    .resetn              (resetn),
    .push                (push),
    .pop                 (pop),
    .peek                (peek),
    .write_data          (write_data),
    .read_data           (read_data),
    .full                (full),
    .empty               (empty),
    .count               (count),
    .overflow            (overflow),
    .underflow           (underflow),
    .memory_enable       (memory_enable),
    .memory_write_enable (memory_write_enable),
    .memory_address      (memory_address),
    .memory_write_data   (memory_write_data),
    .memory_read_data    (memory_read_data)
  );

  stack_memory #(
    .WIDTH (WIDTH),
    .DEPTH (DEPTH)
  ) stack_memory_inst (
    .clock               (clock),
    .memory_enable       (memory_enable),
    .memory_write_enable (memory_write_enable),
    .memory_address      (memory_address),
    .memory_write_data   (memory_write_data),
    .memory_read_data    (memory_read_data)
  );

endmodule

`default_nettype wire

//--- tests/lifo_stack_tb.sv
// LIFO stack testbench
`timescale 1ns/1ps
`default_nettype none

module lifo_stack_tb
  import lifo_stack_pkg::*;
;

  localparam string TESTDATA_FILE  = "tests/lifo_stack_testdata.txt";
  localparam int    ACK_WAIT_LIMIT = 4;

  logic     clock;
  logic     resetn;
  logic     cyc;
  logic     stb;
  logic     we;
  wb_addr_t adr;
  wb_data_t dat_w;
  wb_data_t dat_r;
  logic     ack;

  // Operations loaded from the data file
  logic [7:0] op_kind [$];
  wb_addr_t   op_reg [$];
  wb_data_t   op_wdata [$];
  wb_data_t   op_expect [$];

  int error_count = 0;
  int check_count = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  lifo_stack_top #(
    .WIDTH (DEFAULT_WIDTH),
    .DEPTH (DEFAULT_DEPTH)
  ) lifo_stack_top_inst (
    .clock  (clock),
    .resetn (resetn),
    .cyc    (cyc),
    .stb    (stb),
    .we     (we),
    .adr    (adr),
    .dat_w  (dat_w),
    .dat_r  (dat_r),
    .ack    (ack)
  );

  // 4 ns clock
  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // Parse the data file, skipping comments and blank lines
  task automatic load_testdata();
    int         fd;
    int         fields;
    string      line;
    logic [7:0] kind;
    logic [31:0] reg_value;
    wb_data_t   write_value;
    wb_data_t   expected_value;
    fd = $fopen(TESTDATA_FILE, "r");
    if (fd == 0) begin
      error_count++;
      $display("Could not open the test data file %s", TESTDATA_FILE);
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == "#") continue;
      fields = $sscanf(line, "%c %h %h %h", kind, reg_value, write_value, expected_value);
      if (fields != 4) begin
        error_count++;
        $display("Malformed line in the test data file: %s", line);
        continue;
      end
      op_kind.push_back(kind);
      op_reg.push_back(reg_value[1:0]);
      op_wdata.push_back(write_value);
      op_expect.push_back(expected_value);
    end
    $fclose(fd);
  endtask

  // One Wishbone classic access, stb dropped for a cycle afterwards
  task automatic bus_access(input logic write, input wb_addr_t address,
                            input wb_data_t value, output wb_data_t read_value);
    int   waited;
    logic acked;
    waited     = 0;
    acked      = 1'b0;
    read_value = '0;
    @(posedge clock);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= write;
    adr   <= address;
    dat_w <= value;
    // Sample on the falling edge, away from DUT updates
    while (!acked && waited < ACK_WAIT_LIMIT) begin
      @(negedge clock);
      waited++;
      if (ack) begin
        acked      = 1'b1;
        read_value = dat_r;
      end
    end
    @(posedge clock);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
    if (!acked) begin
      error_count++;
      $display("No ack from the DUT within %0d cycles on a %s of register %0d",
               ACK_WAIT_LIMIT, write ? "write" : "read", address);
    end
    // Ack lasts exactly one cycle
    @(negedge clock);
    if (acked && ack) begin
      error_count++;
      $display("Ack stayed high for more than one cycle on a %s of register %0d",
               write ? "write" : "read", address);
    end
  endtask

  task automatic wb_write(input wb_addr_t address, input wb_data_t value);
    wb_data_t unused_read;
    bus_access(1'b1, address, value, unused_read);
  endtask

  task automatic wb_read(input wb_addr_t address, output wb_data_t value);
    bus_access(1'b0, address, '0, value);
  endtask

  // Popped or peeked words
  task automatic check_data(input int index, input wb_data_t expected, input wb_data_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAIL dat_r data at line %0d: expected %08h, actual %08h",
               index, expected, actual);
    end
  endtask

  // Status words
  task automatic check_status(input int index, input wb_data_t expected, input wb_data_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAIL dat_r status at line %0d: expected %08h, actual %08h",
               index, expected, actual);
    end
  endtask

  task automatic run_operation(input int index);
    wb_data_t read_value;
    if (op_kind[index] == "W") begin
      wb_write(op_reg[index], op_wdata[index]);
    end else if (op_kind[index] == "R") begin
      wb_read(op_reg[index], read_value);
      if (op_reg[index] == REG_STATUS) begin
        check_status(index, op_expect[index], read_value);
      end else begin
        check_data(index, op_expect[index], read_value);
      end
    end else begin
      error_count++;
      $display("Unknown operation kind on data line %0d", index);
    end
  endtask

  // Run limit, set once the data file is loaded
  initial begin
    wait (cycle_limit != 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    int index;
    resetn = 1'b0;
    cyc    = 1'b0;
    stb    = 1'b0;
    we     = 1'b0;
    adr    = '0;
    dat_w  = '0;
    load_testdata();
    // Three cycles per access plus margin
    cycle_limit = 4 * op_kind.size() + 100;
    if (op_kind.size() == 0) begin
      error_count++;
      $display("No operations were loaded from the test data file");
    end
    repeat (2) @(posedge clock);
    resetn <= 1'b1;
    for (index = 0; index < op_kind.size(); index++) begin
      run_operation(index);
    end
    @(posedge clock);
    $display("Checks: %0d  Errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- lifo_stack.f
rtl/lifo_stack_pkg.sv
rtl/stack_memory.sv
rtl/lifo_controller.sv
rtl/wb_stack_port.sv
rtl/lifo_stack_top.sv
tests/lifo_stack_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = lifo_stack_tb
RTL_TOP  = lifo_stack_top
FILELIST = lifo_stack.f
OBJ_DIR  = obj_dir
PASS_MSG = ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tests/lifo_stack_testdata.txt
# op reg write_value expected_read, op W or R, register index and values in hex
# write lines carry 00000000 as an unused expected value
R 2 00000000 00000001
W 0 DEAD1111 00000000
W 0 00002222 00000000
W 0 00003333 00000000
W 0 00004444 00000000
W 0 00005555 00000000
W 0 00006666 00000000
W 0 00007777 00000000
W 0 00008888 00000000
R 2 00000000 00000802
W 0 00009999 00000000
R 2 00000000 00000806
R 1 00000000 00008888
R 2 00000000 00000806
W 1 0000ABCD 00000000
R 2 00000000 00000806
R 0 00000000 0000ABCD
R 2 00000000 00000704
R 0 00000000 00007777
R 0 00000000 00006666
R 0 00000000 00005555
R 0 00000000 00004444
R 0 00000000 00003333
R 0 00000000 00002222
R 0 00000000 00001111
R 2 00000000 00000005
R 0 00000000 00000000
R 2 00000000 0000000D
R 1 00000000 00000000
W 1 00001234 00000000
R 3 00000000 00000000
R 2 00000000 0000000D
W 2 00000000 00000000
R 2 00000000 00000001
W 3 0000FFFF 00000000
R 3 00000000 00000000
R 2 00000000 00000001
W 0 00005A5A 00000000
R 1 00000000 00005A5A
R 2 00000000 00000100
R 0 00000000 00005A5A
R 2 00000000 00000001
